/* verilog/eq_defines.svh */
`ifndef EQ_DEFINES_SVH
`define EQ_DEFINES_SVH

// width of one I or Q component
`define EQ_SAMPLE_W 16

// subcarriers per symbol and the matching address width
`define EQ_FFT_LEN 64
`define EQ_FFT_AW 6

// left shift of the numerators before division, sets the constellation scale
`define EQ_SCALE_SHIFT 7

// data subcarriers that leave the design per symbol
`define EQ_NUM_DATA 48

// buffer depths
`define EQ_IN_DEPTH 64
`define EQ_OUT_DEPTH 8

`endif

/* verilog/sample_pkg.sv */
`include "eq_defines.svh"

package sample_pkg;

    // one complex sample, I in the upper half
    typedef struct packed {
        logic signed [`EQ_SAMPLE_W-1:0] i;
        logic signed [`EQ_SAMPLE_W-1:0] q;
    } cplx_t;

    // products, dividends and quotients
    typedef logic signed [31:0] wide_t;

endpackage

/* verilog/ofdm_pkg.sv */
`include "eq_defines.svh"

package ofdm_pkg;

    // bit k is subcarrier k, bit 0 is DC
    // bits 1..26 are +1..+26, bits 38..63 are -26..-1
    localparam logic [`EQ_FFT_LEN-1:0] USED_MASK =
        64'b1111111111111111111111111100000000000111111111111111111111111110;

    // pilots at -21, -7, +7, +21
    localparam logic [`EQ_FFT_LEN-1:0] PILOT_MASK =
        64'b0000001000000000000010000000000000000000001000000000000010000000;

    // 48 data subcarriers
    localparam logic [`EQ_FFT_LEN-1:0] DATA_MASK = USED_MASK ^ PILOT_MASK;

    // set where the long training symbol carries -1
    localparam logic [`EQ_FFT_LEN-1:0] LTS_REF =
        64'b0000101001100000010100110000000000000000010101100111110101001100;

    // estimator progress through a packet
    typedef enum logic [1:0] {
        ph_first_lts,
        ph_second_lts,
        ph_data
    } est_phase_t;

endpackage

/* verilog/sample_fifo.sv */
`timescale 1ns/1ns

module sample_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int depth = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t push_data_i,
    input  logic     push_valid_i,
    output logic     push_ready_o,
    output payload_t pop_data_o,
    output logic     pop_valid_o,
    input  logic     pop_ready_i
);

    localparam int aw = $clog2(depth);
    localparam int cw = aw + 1;

    payload_t mem [depth];

    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic [cw-1:0] count_next;
    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign do_push = push_valid_i && !full;
    assign do_pop = pop_ready_i && !empty;

    assign push_ready_o = !full;
    assign pop_valid_o = !empty;
    // head of the queue, valid one cycle after its push
    assign pop_data_o = mem[rd_ptr];

    assign count_next = count + cw'(do_push) - cw'(do_pop);

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // flags follow the next occupancy so they come straight from flops
            full <= (count_next == cw'(depth));
            empty <= (count_next == '0);
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // the registered full flag must block every push at full occupancy
    a_no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        do_push |-> (count < cw'(depth)));

endmodule

/* verilog/channel_estimator.sv */
`timescale 1ns/1ns
`include "eq_defines.svh"

module channel_estimator (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    pkt_start_i,
    input  sample_pkg::cplx_t       in_data_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    output sample_pkg::cplx_t       fwd_data_o,
    output logic                    fwd_valid_o,
    input  logic                    fwd_ready_i,
    input  logic [`EQ_FFT_AW-1:0]   est_raddr_i,
    output sample_pkg::cplx_t       est_rdata_o,
    output logic                    est_done_o
);

    // (a + b) / 2 with the reference sign applied
    function automatic logic signed [`EQ_SAMPLE_W-1:0] lts_avg(
        input logic signed [`EQ_SAMPLE_W-1:0] a,
        input logic signed [`EQ_SAMPLE_W-1:0] b,
        input logic neg
    );
        logic signed [`EQ_SAMPLE_W:0] sum;
        logic signed [`EQ_SAMPLE_W-1:0] half;
        sum = {a[`EQ_SAMPLE_W-1], a} + {b[`EQ_SAMPLE_W-1], b};
        half = sum[`EQ_SAMPLE_W:1];
        return neg ? -half : half;
    endfunction

    sample_pkg::cplx_t ram [`EQ_FFT_LEN];

    ofdm_pkg::est_phase_t phase;
    logic [`EQ_FFT_AW-1:0] cnt;
    logic [`EQ_FFT_AW-1:0] rd_addr;
    logic accept_lts;
    logic est_done;

    // write pipeline, one cycle behind the accepted LTS sample
    logic wr_pend;
    logic wr_avg;
    logic wr_neg;
    logic [`EQ_FFT_AW-1:0] wr_addr;
    sample_pkg::cplx_t wr_sample;
    sample_pkg::cplx_t wr_word;
    sample_pkg::cplx_t rd_q;

    // training symbols are always taken, data waits on the input FIFO
    assign in_ready_o = (phase == ofdm_pkg::ph_data) ? fwd_ready_i : 1'b1;
    assign fwd_valid_o = in_valid_i && (phase == ofdm_pkg::ph_data);
    assign fwd_data_o = in_data_i;
    assign accept_lts = in_valid_i && (phase != ofdm_pkg::ph_data);

    // one read port, shared between the second LTS and the equalizer
    assign rd_addr = (phase == ofdm_pkg::ph_data) ? est_raddr_i : cnt;
    assign est_rdata_o = rd_q;
    assign est_done_o = est_done;

    always_comb begin
        if (wr_avg) begin
            wr_word.i = lts_avg(rd_q.i, wr_sample.i, wr_neg);
            wr_word.q = lts_avg(rd_q.q, wr_sample.q, wr_neg);
        end else begin
            wr_word = wr_sample;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= ofdm_pkg::ph_first_lts;
            cnt <= '0;
            wr_pend <= 1'b0;
            wr_avg <= 1'b0;
            est_done <= 1'b0;
        end else begin
            wr_pend <= accept_lts && !pkt_start_i;
            // estimate complete once the last averaged carrier is stored
            if (wr_pend && wr_avg && wr_addr == '1) begin
                est_done <= 1'b1;
            end
            if (pkt_start_i) begin
                phase <= ofdm_pkg::ph_first_lts;
                cnt <= '0;
                est_done <= 1'b0;
            end else if (accept_lts) begin
                wr_avg <= (phase == ofdm_pkg::ph_second_lts);
                cnt <= cnt + 1'b1;
                if (cnt == '1) begin
                    phase <= (phase == ofdm_pkg::ph_first_lts) ?
                        ofdm_pkg::ph_second_lts : ofdm_pkg::ph_data;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept_lts) begin
            wr_addr <= cnt;
            wr_sample <= in_data_i;
            wr_neg <= ofdm_pkg::LTS_REF[cnt];
        end
        rd_q <= ram[rd_addr];
        if (wr_pend) begin
            ram[wr_addr] <= wr_word;
        end
    end

    // once the estimate is complete the data phase only reads the RAM
    a_no_data_write: assert property (@(posedge clock) disable iff (reset)
        (phase == ofdm_pkg::ph_data && est_done) |-> !wr_pend);

endmodule

/* verilog/complex_divider.sv */
`timescale 1ns/1ns
`include "eq_defines.svh"

module complex_divider (
    input  logic              clock,
    input  logic              reset,
    input  logic              start_i,
    input  sample_pkg::wide_t num_i_i,
    input  sample_pkg::wide_t num_q_i,
    input  sample_pkg::wide_t den_i,
    output logic              busy_o,
    output logic              done_o,
    output sample_pkg::wide_t quot_i_o,
    output sample_pkg::wide_t quot_q_o
);

    localparam int steps = `EQ_SAMPLE_W + 16;
    localparam int cw = $clog2(steps);

    function automatic logic [31:0] magnitude(input sample_pkg::wide_t v);
        logic [31:0] m;
        m = v;
        if (v[31]) begin
            m = ~m + 1'b1;
        end
        return m;
    endfunction

    // one restoring step, returns {remainder, shifted quotient}
    function automatic logic [63:0] div_step(
        input logic [31:0] rem,
        input logic [31:0] acc,
        input logic [31:0] den
    );
        logic [32:0] sh;
        logic [33:0] diff;
        logic [31:0] rem_n;
        logic bit_n;
        sh = {rem, acc[31]};
        diff = {1'b0, sh} - {2'b00, den};
        bit_n = !diff[33];
        rem_n = bit_n ? diff[31:0] : sh[31:0];
        return {rem_n, acc[30:0], bit_n};
    endfunction

    logic busy;
    logic done;
    logic [cw-1:0] cnt;
    logic [31:0] rem_i;
    logic [31:0] rem_q;
    logic [31:0] acc_i;
    logic [31:0] acc_q;
    logic [31:0] den_mag;
    logic neg_i;
    logic neg_q;
    logic den_zero;
    logic [63:0] step_i;
    logic [63:0] step_q;
    logic load;
    logic last;

    assign load = start_i && !busy;
    assign last = busy && (cnt == cw'(steps - 2));
    assign step_i = div_step(rem_i, acc_i, den_mag);
    assign step_q = div_step(rem_q, acc_q, den_mag);
    assign busy_o = busy;
    assign done_o = done;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // first quotient bit is taken while loading
    always_ff @(posedge clock) begin
        if (load) begin
            {rem_i, acc_i} <= div_step('0, magnitude(num_i_i), magnitude(den_i));
            {rem_q, acc_q} <= div_step('0, magnitude(num_q_i), magnitude(den_i));
            den_mag <= magnitude(den_i);
            neg_i <= num_i_i[31] ^ den_i[31];
            neg_q <= num_q_i[31] ^ den_i[31];
            den_zero <= (den_i == '0);
        end else if (busy) begin
            {rem_i, acc_i} <= step_i;
            {rem_q, acc_q} <= step_q;
            if (last) begin
                quot_i_o <= den_zero ? '0 : (neg_i ? -step_i[31:0] : step_i[31:0]);
                quot_q_o <= den_zero ? '0 : (neg_q ? -step_q[31:0] : step_q[31:0]);
            end
        end
    end

    a_no_start_busy: assert property (@(posedge clock) disable iff (reset)
        start_i |-> !busy_o);

endmodule

/* verilog/symbol_equalizer.sv */
`timescale 1ns/1ns
`include "eq_defines.svh"

module symbol_equalizer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  est_done_i,
    input  sample_pkg::cplx_t     sym_data_i,
    input  logic                  sym_valid_i,
    output logic                  sym_ready_o,
    output logic [`EQ_FFT_AW-1:0] est_raddr_o,
    input  sample_pkg::cplx_t     est_rdata_i,
    output sample_pkg::cplx_t     eq_data_o,
    output logic                  eq_valid_o,
    input  logic                  eq_ready_i
);

    logic [`EQ_FFT_AW-1:0] sc_idx;
    logic [`EQ_FFT_AW-1:0] held_idx;
    logic held_valid;
    sample_pkg::cplx_t held_x;
    logic pop;
    logic is_data;

    logic res_valid;
    sample_pkg::cplx_t res_data;

    sample_pkg::wide_t xi;
    sample_pkg::wide_t xq;
    sample_pkg::wide_t hi;
    sample_pkg::wide_t hq;
    sample_pkg::wide_t prod_re;
    sample_pkg::wide_t prod_im;
    sample_pkg::wide_t mag_sq;

    logic div_start;
    logic div_busy;
    logic div_done;
    sample_pkg::wide_t quot_i;
    sample_pkg::wide_t quot_q;

    // fetch the next sample as soon as the hold slot is free
    assign sym_ready_o = est_done_i && !held_valid;
    assign pop = sym_ready_o && sym_valid_i;
    assign is_data = ofdm_pkg::DATA_MASK[sc_idx];

    // address stays on the held carrier so the estimate stays put
    assign est_raddr_o = held_valid ? held_idx : sc_idx;

    assign xi = held_x.i;
    assign xq = held_x.q;
    assign hi = est_rdata_i.i;
    assign hq = est_rdata_i.q;

    // x * conj(h) and |h|^2
    assign prod_re = xi * hi + xq * hq;
    assign prod_im = xq * hi - xi * hq;
    assign mag_sq = hi * hi + hq * hq;

    assign div_start = held_valid && !div_busy && !res_valid && eq_ready_i;

    assign eq_valid_o = res_valid;
    assign eq_data_o = res_data;

    always_ff @(posedge clock) begin
        if (reset || !est_done_i) begin
            sc_idx <= '0;
            held_valid <= 1'b0;
        end else begin
            if (pop) begin
                sc_idx <= sc_idx + 1'b1;
                // null and pilot carriers are dropped here
                if (is_data) begin
                    held_valid <= 1'b1;
                end
            end else if (div_start) begin
                held_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            held_x <= sym_data_i;
            held_idx <= sc_idx;
        end
        if (div_done) begin
            res_data.i <= quot_i[`EQ_SAMPLE_W-1:0];
            res_data.q <= quot_q[`EQ_SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (div_done) begin
            res_valid <= 1'b1;
        end else if (eq_ready_i) begin
            res_valid <= 1'b0;
        end
    end

    complex_divider div0 (
        .clock    (clock),
        .reset    (reset),
        .start_i  (div_start),
        .num_i_i  (prod_re <<< `EQ_SCALE_SHIFT),
        .num_q_i  (prod_im <<< `EQ_SCALE_SHIFT),
        .den_i    (mag_sq),
        .busy_o   (div_busy),
        .done_o   (div_done),
        .quot_i_o (quot_i),
        .quot_q_o (quot_q)
    );

endmodule

/* verilog/ofdm_equalizer.sv */
`timescale 1ns/1ns
`include "eq_defines.svh"

module ofdm_equalizer (
    input  logic              clock,
    input  logic              reset,
    input  logic              pkt_start_i,
    input  sample_pkg::cplx_t in_data_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output sample_pkg::cplx_t out_data_o,
    output logic              out_valid_o,
    input  logic              out_ready_i
);

    sample_pkg::cplx_t fwd_data;
    logic fwd_valid;
    logic fwd_ready;
    sample_pkg::cplx_t sym_data;
    logic sym_valid;
    logic sym_ready;
    logic [`EQ_FFT_AW-1:0] est_raddr;
    sample_pkg::cplx_t est_rdata;
    logic est_done;
    sample_pkg::cplx_t eq_data;
    logic eq_valid;
    logic eq_ready;

    channel_estimator est0 (
        .clock       (clock),
        .reset       (reset),
        .pkt_start_i (pkt_start_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .fwd_data_o  (fwd_data),
        .fwd_valid_o (fwd_valid),
        .fwd_ready_i (fwd_ready),
        .est_raddr_i (est_raddr),
        .est_rdata_o (est_rdata),
        .est_done_o  (est_done)
    );

    sample_fifo #(
        .payload_t (sample_pkg::cplx_t),
        .depth     (`EQ_IN_DEPTH)
    ) fifo_in (
        .clock        (clock),
        .reset        (reset),
        .push_data_i  (fwd_data),
        .push_valid_i (fwd_valid),
        .push_ready_o (fwd_ready),
        .pop_data_o   (sym_data),
        .pop_valid_o  (sym_valid),
        .pop_ready_i  (sym_ready)
    );

    symbol_equalizer eq0 (
        .clock       (clock),
        .reset       (reset),
        .est_done_i  (est_done),
        .sym_data_i  (sym_data),
        .sym_valid_i (sym_valid),
        .sym_ready_o (sym_ready),
        .est_raddr_o (est_raddr),
        .est_rdata_i (est_rdata),
        .eq_data_o   (eq_data),
        .eq_valid_o  (eq_valid),
        .eq_ready_i  (eq_ready)
    );

    sample_fifo #(
        .payload_t (sample_pkg::cplx_t),
        .depth     (`EQ_OUT_DEPTH)
    ) fifo_out (
        .clock        (clock),
        .reset        (reset),
        .push_data_i  (eq_data),
        .push_valid_i (eq_valid),
        .push_ready_o (eq_ready),
        .pop_data_o   (out_data_o),
        .pop_valid_o  (out_valid_o),
        .pop_ready_i  (out_ready_i)
    );

endmodule

/* verification/tb_ofdm_equalizer.sv */
`timescale 1ns/1ns
`include "eq_defines.svh"

module tb_ofdm_equalizer;

    logic clock;
    logic reset;
    logic pkt_start_i;
    sample_pkg::cplx_t in_data_i;
    logic in_valid_i;
    logic in_ready_o;
    sample_pkg::cplx_t out_data_o;
    logic out_valid_o;
    logic out_ready_i;

    // stimulus read from the data file
    logic [63:0] lts_ref;
    logic [63:0] data_mask;
    int pkt_test[$];
    int pkt_rand[$];
    int pkt_first[$];
    int pkt_nsym[$];
    int lts_par[$];
    logic [47:0] sym_imask[$];
    logic [47:0] sym_qmask[$];
    int sym_amp[$];
    int sym_exp[$];

    sample_pkg::cplx_t got_q[$];
    sample_pkg::cplx_t ref_q[$];
    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;
    logic [31:0] lfsr_state;
    logic random_mode;
    logic gap_pending;
    logic lts_active;
    logic stim_ok;

    ofdm_equalizer dut0 (
        .clock       (clock),
        .reset       (reset),
        .pkt_start_i (pkt_start_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic take_bit();
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'hA3000000;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
        return lfsr_state[0];
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        check_count++;
        if (actual != expected) begin
            $display("ERR %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic read_stim(output logic ok);
        int fd;
        int a;
        int b;
        int c;
        int d;
        logic [47:0] m0;
        logic [47:0] m1;
        string line;
        string rest;
        ok = 1'b0;
        fd = $fopen("verification/equalizer_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    rest = line.substr(1, line.len() - 1);
                    case (line[0])
                        "R": a = $sscanf(rest, "%h", lts_ref);
                        "M": a = $sscanf(rest, "%h", data_mask);
                        "P": begin
                            if ($sscanf(rest, "%d %d", a, b) == 2) begin
                                pkt_test.push_back(a);
                                pkt_rand.push_back(b);
                                pkt_first.push_back(sym_amp.size());
                                pkt_nsym.push_back(0);
                            end
                        end
                        "L": begin
                            if ($sscanf(rest, "%d %d %d %d", a, b, c, d) == 4) begin
                                lts_par.push_back(a);
                                lts_par.push_back(b);
                                lts_par.push_back(c);
                                lts_par.push_back(d);
                            end
                        end
                        "D": begin
                            if ($sscanf(rest, "%h %h %d %d", m0, m1, a, b) == 4) begin
                                sym_imask.push_back(m0);
                                sym_qmask.push_back(m1);
                                sym_amp.push_back(a);
                                sym_exp.push_back(b);
                                pkt_nsym[pkt_nsym.size() - 1] += 1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
            ok = (pkt_test.size() > 0) && (lts_par.size() == 8 * pkt_test.size());
        end
    endtask

    // channel of one training line, h(k) = (hi + di*(k%8), hq + dq*(k%5))
    function automatic int chan_re(input int base, input int k);
        return lts_par[base] + lts_par[base + 2] * (k % 8);
    endfunction

    function automatic int chan_im(input int base, input int k);
        return lts_par[base + 1] + lts_par[base + 3] * (k % 5);
    endfunction

    // called 1 ns after a rising edge, returns at the same point after acceptance
    task automatic send_sample(input int re, input int im);
        logic accepted;
        while (gap_pending) begin
            in_valid_i = 1'b0;
            @(negedge clock);
            gap_pending = take_bit();
            @(posedge clock);
            #1;
        end
        in_data_i.i = 16'(re);
        in_data_i.q = 16'(im);
        in_valid_i = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock);
            // training symbols are never held off
            if (lts_active) begin
                check_value(int'(in_ready_o), 1, "in_ready_o during training symbols");
            end
            accepted = in_ready_o;
            if (accepted && random_mode) begin
                gap_pending = take_bit();
            end
            @(posedge clock);
            #1;
        end
    endtask

    task automatic run_packet(input int p);
        int errs_before;
        int base;
        int sgn;
        int hr;
        int hi;
        int si;
        int sq;
        int j;
        int idx;
        int expect_i;
        int expect_q;
        errs_before = error_count;
        base = 8 * p;
        got_q.delete();
        gap_pending = 1'b0;
        pkt_start_i = 1'b1;
        @(negedge clock);
        random_mode = pkt_rand[p][0];
        @(posedge clock);
        #1;
        pkt_start_i = 1'b0;
        lts_active = 1'b1;
        for (int l = 0; l < 2; l++) begin
            for (int k = 0; k < `EQ_FFT_LEN; k++) begin
                sgn = lts_ref[k] ? -1 : 1;
                send_sample(sgn * chan_re(base + 4 * l, k), sgn * chan_im(base + 4 * l, k));
            end
        end
        lts_active = 1'b0;
        for (int s = pkt_first[p]; s < pkt_first[p] + pkt_nsym[p]; s++) begin
            j = 0;
            for (int k = 0; k < `EQ_FFT_LEN; k++) begin
                if (data_mask[k]) begin
                    // data sample is x = h * s with h the mean of the two training lines
                    hr = (chan_re(base, k) + chan_re(base + 4, k)) / 2;
                    hi = (chan_im(base, k) + chan_im(base + 4, k)) / 2;
                    si = sym_imask[s][j] ? -sym_amp[s] : sym_amp[s];
                    sq = sym_qmask[s][j] ? -sym_amp[s] : sym_amp[s];
                    send_sample(hr * si - hi * sq, hr * sq + hi * si);
                    j++;
                end else begin
                    send_sample(k, -k);
                end
            end
        end
        in_valid_i = 1'b0;
        while (got_q.size() < `EQ_NUM_DATA * pkt_nsym[p]) begin
            @(posedge clock);
        end
        // quiet window, nothing more may come out
        repeat (50) @(posedge clock);
        #1;
        check_value(got_q.size(), `EQ_NUM_DATA * pkt_nsym[p], "output count");
        idx = 0;
        for (int s = pkt_first[p]; s < pkt_first[p] + pkt_nsym[p]; s++) begin
            for (int n = 0; n < `EQ_NUM_DATA; n++) begin
                expect_i = sym_imask[s][n] ? -sym_exp[s] : sym_exp[s];
                expect_q = sym_qmask[s][n] ? -sym_exp[s] : sym_exp[s];
                check_value(int'(got_q[idx].i), expect_i, $sformatf("symbol %0d carrier %0d I", s, n));
                check_value(int'(got_q[idx].q), expect_q, $sformatf("symbol %0d carrier %0d Q", s, n));
                idx++;
            end
        end
        if (pkt_test[p] == 2) begin
            ref_q = got_q;
        end
        // back-pressure run must reproduce the undisturbed sequence
        if (pkt_test[p] == 4) begin
            check_value(got_q.size(), ref_q.size(), "output count against test 2");
            for (int n = 0; n < got_q.size() && n < ref_q.size(); n++) begin
                check_value(got_q[n], ref_q[n], $sformatf("output %0d against test 2", n));
            end
        end
        $display("test %0d: %0d outputs, %s", pkt_test[p], got_q.size(),
            (error_count == errs_before) ? "ok" : "mismatches");
    endtask

    // output monitor, outputs are stable at the falling edge
    always @(negedge clock) begin
        if (!reset && out_valid_o && out_ready_i) begin
            got_q.push_back(out_data_o);
            if (lts_active) begin
                $display("an output appeared while training symbols were being sent");
                error_count++;
            end
        end
    end

    always @(posedge clock) begin
        #1;
        if (random_mode) begin
            out_ready_i = take_bit();
        end else begin
            out_ready_i = 1'b1;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped producing outputs", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        pkt_start_i = 1'b0;
        in_data_i = '0;
        in_valid_i = 1'b0;
        out_ready_i = 1'b1;
        lfsr_state = 32'h94ab9232;
        random_mode = 1'b0;
        gap_pending = 1'b0;
        lts_active = 1'b0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        cycle_limit = 1000;
        read_stim(stim_ok);
        if (!stim_ok) begin
            $display("the stimulus file could not be opened or is incomplete");
            $display("Test failed");
            $finish;
        end else begin
            cycle_limit = (2 * pkt_test.size() + sym_amp.size()) * `EQ_FFT_LEN * 40 + 1000;
            repeat (4) @(posedge clock);
            #1;
            reset = 1'b0;
            // state right after reset
            check_value(int'(in_ready_o), 1, "in_ready_o after reset");
            check_value(int'(out_valid_o), 0, "out_valid_o after reset");
            for (int p = 0; p < pkt_test.size(); p++) begin
                run_packet(p);
            end
            $display("summary: %0d tests, %0d checks, %0d errors", pkt_test.size(),
                check_count, error_count);
            if (error_count == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

/* verification/equalizer_stim.txt */
# R lts_ref_hex | M data_mask_hex | P test random | L hi hq di dq, h(k)=(hi+di*(k%8), hq+dq*(k%5))
# D imask qmask amp expected, bit j set makes data carrier j negative, output is +-expected
R 0A60530000567D4C
M FDFFF7C007DFFF7E
P 1 0
L 256 0 0 0
L 256 0 0 0
D 000000000000 000000000000 1 128
D A5C3F0129B7E 3C96E15A0FF1 1 128
P 2 0
L 340 -180 40 70
L 260 -220 40 70
D 5A5A5A5A5A5A FF00FF00FF00 1 128
D 123456789ABC FEDCBA987654 2 256
D 0F0F0F0F0F0F 33CC33CC33CC 3 384
P 3 0
L -150 90 0 -30
L -150 90 0 -30
D FFFFFFFFFFFF 000000000000 1 128
D 000000000000 FFFFFFFFFFFF 2 256
D 9E3779B97F4A 7C15C8D2A1E3 3 384
D 6B2F0C19A4D5 D1E0F7A28B36 1 128
P 4 1
L 340 -180 40 70
L 260 -220 40 70
D 5A5A5A5A5A5A FF00FF00FF00 1 128
D 123456789ABC FEDCBA987654 2 256
D 0F0F0F0F0F0F 33CC33CC33CC 3 384
P 5 0
L 120 400 -10 0
L 80 360 -10 0
D 3C3C3C3C3C3C A5A5A5A5A5A5 3 384
D E1D2C3B4A596 0123456789AB 2 256

/* src.f */
+incdir+verilog
verilog/sample_pkg.sv
verilog/ofdm_pkg.sv
verilog/sample_fifo.sv
verilog/channel_estimator.sv
verilog/complex_divider.sv
verilog/symbol_equalizer.sv
verilog/ofdm_equalizer.sv
verification/tb_ofdm_equalizer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the equalizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_ofdm_equalizer

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module "$TOP" -o sim_"$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
